// ==== logic/vwrite_pkg.sv ====
package vwrite_pkg;

   // datapath and databus word
   localparam int DATA_W = 32;

   // byte strobes per databus word
   localparam int STRB_W = DATA_W / 8;

   // buffer address, top bit doubles as the bank bit in ping-pong mode
   localparam int ADDR_W = 10;

   // period and duty fields of the address generators
   localparam int PERIOD_W = 8;

   // store side start delay
   localparam int DELAY_W = 7;

   // burst length and word count
   localparam int LEN_W = 8;

   // external byte address
   localparam int AXI_ADDR_W = 32;

   // words in the local buffer
   localparam int BUF_DEPTH = 1 << ADDR_W;

endpackage

// ==== logic/vwrite_if.sv ====
`timescale 1ns/1ps

// configuration of one two-level address generator
interface addr_cfg_if import vwrite_pkg::*; ();

   logic [ADDR_W-1:0]   start;
   logic [PERIOD_W-1:0] per;
   logic [PERIOD_W-1:0] duty;
   logic [ADDR_W-1:0]   incr;
   logic [ADDR_W-1:0]   iter;
   logic [ADDR_W-1:0]   shift;

   modport src (
      output start, per, duty, incr, iter, shift
   );

   modport gen (
      input start, per, duty, incr, iter, shift
   );

endinterface

// word stream with back-pressure
interface wstream_if import vwrite_pkg::*; ();

   logic              valid;
   logic              ready;
   logic [DATA_W-1:0] data;
   logic              last;

   modport src (
      output valid, data, last,
      input  ready
   );

   modport dst (
      input  valid, data, last,
      output ready
   );

endinterface

// ==== logic/addr_gen.sv ====
`timescale 1ns/1ps

module addr_gen import vwrite_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              start_i,
   input  logic              advance_i,
   addr_cfg_if.gen           cfg,
   output logic              valid_o,
   output logic [ADDR_W-1:0] addr_o,
   output logic              done_o
);

   logic                active_q;
   logic [PERIOD_W-1:0] step_q;
   logic [ADDR_W-1:0]   iter_q;
   logic [ADDR_W-1:0]   addr_q;
   logic                per_end;
   logic                iter_end;

   // last step of the current period / last period of the run
   assign per_end  = (step_q == cfg.per - PERIOD_W'(1));
   assign iter_end = (iter_q == cfg.iter - ADDR_W'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         step_q   <= '0;
         iter_q   <= '0;
         addr_q   <= '0;
      end else if (start_i) begin
         // zero period or zero iterations finishes at once
         active_q <= (cfg.per != '0) && (cfg.iter != '0);
         step_q   <= '0;
         iter_q   <= '0;
         addr_q   <= cfg.start;
      end else if (advance_i && active_q) begin
         if (per_end) begin
            // period boundary takes shift in place of incr
            step_q <= '0;
            iter_q <= iter_q + ADDR_W'(1);
            addr_q <= addr_q + cfg.shift;
            if (iter_end) begin
               active_q <= 1'b0;
            end
         end else begin
            step_q <= step_q + PERIOD_W'(1);
            addr_q <= addr_q + cfg.incr;
         end
      end
   end

   // steps past the duty window are skipped but still counted
   assign valid_o = active_q && (step_q < cfg.duty);
   assign addr_o  = addr_q;
   assign done_o  = !active_q;

endmodule

// ==== logic/store_path.sv ====
`timescale 1ns/1ps

module store_path import vwrite_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               run_i,
   input  logic               running_i,
   input  logic [DELAY_W-1:0] delay_i,
   input  logic [DATA_W-1:0]  in_i,
   addr_cfg_if.gen            cfg,
   output logic               wr_en_o,
   output logic [ADDR_W-1:0]  wr_addr_o,
   output logic [DATA_W-1:0]  wr_data_o,
   output logic               done_o
);

   logic [DELAY_W-1:0] delay_q;
   logic               advance;
   logic               gen_valid;
   logic [ADDR_W-1:0]  gen_addr;

   // start delay only counts cycles where the datapath runs
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay_q <= '0;
      end else if (run_i) begin
         delay_q <= delay_i;
      end else if (running_i && (delay_q != '0)) begin
         delay_q <= delay_q - DELAY_W'(1);
      end
   end

   assign advance = running_i && (delay_q == '0);

   addr_gen u_gen (
      .clk       (clk),
      .rst       (rst),
      .start_i   (run_i),
      .advance_i (advance),
      .cfg       (cfg),
      .valid_o   (gen_valid),
      .addr_o    (gen_addr),
      .done_o    (done_o)
   );

   // write the word present on the same cycle as the step
   assign wr_en_o   = advance && gen_valid;
   assign wr_addr_o = gen_addr;
   assign wr_data_o = in_i;

endmodule

// ==== logic/xfer_reader.sv ====
`timescale 1ns/1ps

module xfer_reader import vwrite_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic [DATA_W-1:0] rd_data_i,
   addr_cfg_if.gen           cfg,
   output logic              rd_en_o,
   output logic [ADDR_W-1:0] rd_addr_o,
   wstream_if.src            strm
);

   logic              gen_valid;
   logic              gen_done;
   logic [ADDR_W-1:0] gen_addr;
   logic              advance;
   logic              pop;
   logic              land;
   logic              pend_q;
   logic              hold_valid_q;
   logic [DATA_W-1:0] hold_data_q;

   assign pop  = hold_valid_q && strm.ready;
   // pending read moves into the hold register when it is free
   assign land = pend_q && (!hold_valid_q || pop);
   // a new read may only replace the buffer output once it has landed
   assign advance = !gen_done && (!pend_q || land);

   addr_gen u_gen (
      .clk       (clk),
      .rst       (rst),
      .start_i   (run_i),
      .advance_i (advance),
      .cfg       (cfg),
      .valid_o   (gen_valid),
      .addr_o    (gen_addr),
      .done_o    (gen_done)
   );

   assign rd_en_o   = advance && gen_valid;
   assign rd_addr_o = gen_addr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pend_q       <= 1'b0;
         hold_valid_q <= 1'b0;
      end else begin
         pend_q <= rd_en_o || (pend_q && !land);
         if (land) begin
            hold_valid_q <= 1'b1;
         end else if (pop) begin
            hold_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (land) begin
         hold_data_q <= rd_data_i;
      end
   end

   assign strm.valid = hold_valid_q;
   assign strm.data  = hold_data_q;
   // nothing behind the held word once the generator is done
   assign strm.last  = hold_valid_q && !pend_q && gen_done;

endmodule

// ==== logic/databus_writer.sv ====
`timescale 1ns/1ps

module databus_writer import vwrite_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic [LEN_W-1:0]      amount_minus_one_i,
   input  logic [LEN_W-1:0]      write_length_i,
   input  logic [AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [AXI_ADDR_W-1:0] addr_shift_i,
   wstream_if.dst                strm,
   output logic                  valid_o,
   output logic [AXI_ADDR_W-1:0] addr_o,
   output logic [LEN_W-1:0]      len_o,
   output logic [DATA_W-1:0]     wdata_o,
   output logic [STRB_W-1:0]     wstrb_o,
   input  logic                  ready_i,
   input  logic                  last_i,
   output logic                  done_o
);

   logic                  in_burst_q;
   // words not yet claimed by a burst, one bit wider for the full count
   logic [LEN_W:0]        left_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]      len_q;
   logic [LEN_W-1:0]      next_len;
   logic                  start_burst;
   logic                  beat;
   logic                  burst_end;

   assign next_len    = ({1'b0, write_length_i} < left_q) ? write_length_i
                                                          : left_q[LEN_W-1:0];
   assign start_burst = !in_burst_q && (left_q != '0) && strm.valid;
   assign beat        = valid_o && ready_i;
   assign burst_end   = beat && last_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         in_burst_q <= 1'b0;
         left_q     <= '0;
      end else if (run_i) begin
         in_burst_q <= 1'b0;
         left_q     <= {1'b0, amount_minus_one_i} + (LEN_W + 1)'(1);
      end else if (start_burst) begin
         in_burst_q <= 1'b1;
         left_q     <= left_q - {1'b0, next_len};
      end else if (burst_end) begin
         in_burst_q <= 1'b0;
         if (done_o) begin
            left_q <= '0;
         end
      end
   end

   // burst address and length stay put for the whole burst
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q <= ext_addr_i;
      end else if (burst_end) begin
         addr_q <= addr_q + addr_shift_i;
      end
      if (start_burst) begin
         len_q <= next_len;
      end
   end

   // beats wait on the stream, valid only dips where the stream has a gap
   assign valid_o    = in_burst_q && strm.valid;
   assign strm.ready = in_burst_q && ready_i;
   assign addr_o     = addr_q;
   assign len_o      = len_q;
   assign wdata_o    = strm.data;
   assign wstrb_o    = '1;
   assign done_o     = burst_end && ((left_q == '0) || strm.last);

endmodule

// ==== logic/vwrite_buffer.sv ====
`timescale 1ns/1ps

module vwrite_buffer import vwrite_pkg::*; (
   input  logic              clk,
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [DATA_W-1:0] wr_data_i,
   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output logic [DATA_W-1:0] rd_data_o
);

   logic [DATA_W-1:0] mem [BUF_DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
      // read data holds until the next read
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== logic/vwrite_ctrl.sv ====
`timescale 1ns/1ps

module vwrite_ctrl import vwrite_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              pingpong_i,
   input  logic              store_done_i,
   input  logic              xfer_done_i,
   input  logic              write_enabled_i,
   input  logic [ADDR_W-1:0] store_addr_i,
   input  logic [ADDR_W-1:0] xfer_addr_i,
   output logic [ADDR_W-1:0] bank_store_addr_o,
   output logic [ADDR_W-1:0] bank_xfer_addr_o,
   output logic              done_o
);

   logic bank_q;
   logic xfer_fin_q;
   logic done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q     <= 1'b0;
         xfer_fin_q <= 1'b1;
         done_q     <= 1'b1;
      end else if (run_i) begin
         bank_q     <= pingpong_i && !bank_q;
         // a disabled transfer counts as finished right away
         xfer_fin_q <= !write_enabled_i;
         done_q     <= 1'b0;
      end else begin
         if (xfer_done_i) begin
            xfer_fin_q <= 1'b1;
         end
         done_q <= store_done_i && (xfer_fin_q || xfer_done_i);
      end
   end

   // store fills the current bank while the other one is sent out
   assign bank_store_addr_o = {pingpong_i ? bank_q : store_addr_i[ADDR_W-1],
                               store_addr_i[ADDR_W-2:0]};
   assign bank_xfer_addr_o  = {pingpong_i ? !bank_q : xfer_addr_i[ADDR_W-1],
                               xfer_addr_i[ADDR_W-2:0]};
   assign done_o            = done_q;

endmodule

// ==== logic/vwrite_top.sv ====
`timescale 1ns/1ps

module vwrite_top import vwrite_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  logic                  running_i,
   input  logic [DATA_W-1:0]     in_i,
   // store generator
   input  logic [ADDR_W-1:0]     store_start_i,
   input  logic [PERIOD_W-1:0]   store_per_i,
   input  logic [PERIOD_W-1:0]   store_duty_i,
   input  logic [ADDR_W-1:0]     store_incr_i,
   input  logic [ADDR_W-1:0]     store_iter_i,
   input  logic [ADDR_W-1:0]     store_shift_i,
   // transfer generator
   input  logic [ADDR_W-1:0]     xfer_start_i,
   input  logic [PERIOD_W-1:0]   xfer_per_i,
   input  logic [PERIOD_W-1:0]   xfer_duty_i,
   input  logic [ADDR_W-1:0]     xfer_incr_i,
   input  logic [ADDR_W-1:0]     xfer_iter_i,
   input  logic [ADDR_W-1:0]     xfer_shift_i,
   input  logic                  write_enabled_i,
   input  logic [LEN_W-1:0]      amount_minus_one_i,
   input  logic [LEN_W-1:0]      write_length_i,
   input  logic [AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [AXI_ADDR_W-1:0] addr_shift_i,
   input  logic                  pingpong_i,
   input  logic [DELAY_W-1:0]    delay_i,
   // databus
   output logic                  databus_valid_o,
   output logic [AXI_ADDR_W-1:0] databus_addr_o,
   output logic [LEN_W-1:0]      databus_len_o,
   output logic [DATA_W-1:0]     databus_wdata_o,
   output logic [STRB_W-1:0]     databus_wstrb_o,
   input  logic                  databus_ready_i,
   input  logic                  databus_last_i,
   output logic                  done_o
);

   addr_cfg_if store_cfg ();
   addr_cfg_if xfer_cfg ();
   wstream_if  strm ();

   logic              xfer_run;
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic [ADDR_W-1:0] wr_addr_bank;
   logic [DATA_W-1:0] wr_data;
   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   logic [ADDR_W-1:0] rd_addr_bank;
   logic [DATA_W-1:0] rd_data;
   logic              store_done;
   logic              xfer_done;

   assign store_cfg.start = store_start_i;
   assign store_cfg.per   = store_per_i;
   assign store_cfg.duty  = store_duty_i;
   assign store_cfg.incr  = store_incr_i;
   assign store_cfg.iter  = store_iter_i;
   assign store_cfg.shift = store_shift_i;

   assign xfer_cfg.start = xfer_start_i;
   assign xfer_cfg.per   = xfer_per_i;
   assign xfer_cfg.duty  = xfer_duty_i;
   assign xfer_cfg.incr  = xfer_incr_i;
   assign xfer_cfg.iter  = xfer_iter_i;
   assign xfer_cfg.shift = xfer_shift_i;

   // transfer side only starts when enabled at the run pulse
   assign xfer_run = run_i && write_enabled_i;

   vwrite_ctrl u_ctrl (
      .clk               (clk),
      .rst               (rst),
      .run_i             (run_i),
      .pingpong_i        (pingpong_i),
      .store_done_i      (store_done),
      .xfer_done_i       (xfer_done),
      .write_enabled_i   (write_enabled_i),
      .store_addr_i      (wr_addr),
      .xfer_addr_i       (rd_addr),
      .bank_store_addr_o (wr_addr_bank),
      .bank_xfer_addr_o  (rd_addr_bank),
      .done_o            (done_o)
   );

   store_path u_store (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .running_i (running_i),
      .delay_i   (delay_i),
      .in_i      (in_i),
      .cfg       (store_cfg),
      .wr_en_o   (wr_en),
      .wr_addr_o (wr_addr),
      .wr_data_o (wr_data),
      .done_o    (store_done)
   );

   xfer_reader u_reader (
      .clk       (clk),
      .rst       (rst),
      .run_i     (xfer_run),
      .rd_data_i (rd_data),
      .cfg       (xfer_cfg),
      .rd_en_o   (rd_en),
      .rd_addr_o (rd_addr),
      .strm      (strm)
   );

   vwrite_buffer u_buffer (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr_bank),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr_bank),
      .rd_data_o (rd_data)
   );

   databus_writer u_writer (
      .clk                (clk),
      .rst                (rst),
      .run_i              (xfer_run),
      .amount_minus_one_i (amount_minus_one_i),
      .write_length_i     (write_length_i),
      .ext_addr_i         (ext_addr_i),
      .addr_shift_i       (addr_shift_i),
      .strm               (strm),
      .valid_o            (databus_valid_o),
      .addr_o             (databus_addr_o),
      .len_o              (databus_len_o),
      .wdata_o            (databus_wdata_o),
      .wstrb_o            (databus_wstrb_o),
      .ready_i            (databus_ready_i),
      .last_i             (databus_last_i),
      .done_o             (xfer_done)
   );

endmodule

// ==== verif/vwrite_tb.sv ====
`timescale 1ns/1ps

module vwrite_tb import vwrite_pkg::*; ();

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  run_i;
   logic                  running_i = 1'b0;
   logic [DATA_W-1:0]     in_i = '0;
   logic [ADDR_W-1:0]     store_start_i, store_incr_i, store_iter_i, store_shift_i;
   logic [PERIOD_W-1:0]   store_per_i, store_duty_i;
   logic [ADDR_W-1:0]     xfer_start_i, xfer_incr_i, xfer_iter_i, xfer_shift_i;
   logic [PERIOD_W-1:0]   xfer_per_i, xfer_duty_i;
   logic                  write_enabled_i;
   logic [LEN_W-1:0]      amount_minus_one_i, write_length_i;
   logic [AXI_ADDR_W-1:0] ext_addr_i, addr_shift_i;
   logic                  pingpong_i;
   logic [DELAY_W-1:0]    delay_i;
   logic                  databus_valid_o;
   logic [AXI_ADDR_W-1:0] databus_addr_o;
   logic [LEN_W-1:0]      databus_len_o;
   logic [DATA_W-1:0]     databus_wdata_o;
   logic [STRB_W-1:0]     databus_wstrb_o;
   logic                  databus_ready_i = 1'b0;
   logic                  databus_last_i = 1'b0;
   logic                  done_o;

   // reference model state
   logic [DATA_W-1:0]     model_mem [BUF_DEPTH];
   logic                  bank;
   logic                  store_fin;
   int                    delay_left;
   int                    store_step;
   logic [DATA_W-1:0]     exp_word_q [$];
   logic [AXI_ADDR_W-1:0] exp_addr_q [$];
   logic [LEN_W-1:0]      exp_len_q [$];

   // slave and monitor state
   logic [15:0]           lfsr = 16'd46556;
   logic                  rdy;
   logic                  last;
   logic                  in_burst = 1'b0;
   logic                  stalled = 1'b0;
   int                    beat_cnt;
   int                    burst_len;
   logic [AXI_ADDR_W-1:0] burst_addr;
   logic [AXI_ADDR_W-1:0] held_addr;
   logic [LEN_W-1:0]      held_len;
   logic [DATA_W-1:0]     held_wdata;
   logic [DATA_W-1:0]     exp_word;
   int                    bit_idx;
   int                    error_count = 0;
   int                    beats_checked = 0;
   int                    bursts_checked = 0;
   logic                  timed_out = 1'b0;

   vwrite_top uut (.*);

   always #50 clk = ~clk;

   // 16 bit Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // address of step n under the two-level rule
   function automatic logic [ADDR_W-1:0] gen_addr(input logic [ADDR_W-1:0] start, input int per,
                                                   input logic [ADDR_W-1:0] incr,
                                                   input logic [ADDR_W-1:0] shift, input int n);
      int outer;
      int inner;
      outer = n / per;
      inner = n % per;
      return ADDR_W'(start + outer * ((per - 1) * incr + shift) + inner * incr);
   endfunction

   function automatic logic [ADDR_W-1:0] with_bank(input logic [ADDR_W-1:0] addr, input logic b);
      return pingpong_i ? {b, addr[ADDR_W-2:0]} : addr;
   endfunction

   task automatic note_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
      error_count++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
   endtask

   task automatic note_error(input string msg);
      error_count++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   // words and bursts the next transfer must produce
   task automatic plan_transfer();
      int count;
      int len;
      int k;
      for (int n = 0; n < xfer_per_i * xfer_iter_i; n++) begin
         if (n % xfer_per_i < xfer_duty_i) begin
            exp_word_q.push_back(model_mem[with_bank(gen_addr(xfer_start_i, xfer_per_i,
                                 xfer_incr_i, xfer_shift_i, n), !bank)]);
         end
      end
      count = amount_minus_one_i + 1;
      k = 0;
      while (count > 0) begin
         len = (write_length_i < count) ? write_length_i : count;
         exp_addr_q.push_back(ext_addr_i + k * addr_shift_i);
         exp_len_q.push_back(LEN_W'(len));
         count -= len;
         k++;
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         bank = 1'b0;
         store_fin = 1'b1;
         delay_left = 0;
         store_step = 0;
      end else if (run_i) begin
         bank = pingpong_i ? !bank : 1'b0;
         delay_left = delay_i;
         store_step = 0;
         store_fin = 1'b0;
         if (write_enabled_i) begin
            plan_transfer();
         end
      end else if (running_i) begin
         if (delay_left > 0) begin
            delay_left--;
         end else if (!store_fin) begin
            if (store_step % store_per_i < store_duty_i) begin
               model_mem[with_bank(gen_addr(store_start_i, store_per_i, store_incr_i,
                         store_shift_i, store_step), bank)] = in_i;
            end
            store_step++;
            if (store_step == store_per_i * store_iter_i) begin
               store_fin = 1'b1;
            end
         end
      end
   end

   // datapath stimulus, databus slave and monitor
   always @(negedge clk) begin
      rdy = 1'b0;
      last = 1'b0;
      lfsr = lfsr_step(lfsr);
      running_i = lfsr[0];
      lfsr = lfsr_step(lfsr);
      running_i = running_i | lfsr[0];
      for (bit_idx = 0; bit_idx < DATA_W; bit_idx++) begin
         lfsr = lfsr_step(lfsr);
         in_i[bit_idx] = lfsr[0];
      end
      if (!rst) begin
         if (stalled) begin
            assert (databus_valid_o === 1'b1)
               else note_mismatch("databus_valid_o", databus_valid_o, 1);
            assert (databus_addr_o === held_addr)
               else note_mismatch("databus_addr_o", databus_addr_o, held_addr);
            assert (databus_len_o === held_len)
               else note_mismatch("databus_len_o", databus_len_o, held_len);
            assert (databus_wdata_o === held_wdata)
               else note_mismatch("databus_wdata_o", databus_wdata_o, held_wdata);
         end
         if (databus_valid_o === 1'b1 && !in_burst) begin
            if (exp_len_q.size() == 0) begin
               note_error("databus burst started with no burst expected");
               burst_addr = databus_addr_o;
               burst_len = databus_len_o;
            end else begin
               burst_addr = exp_addr_q.pop_front();
               burst_len = exp_len_q.pop_front();
               assert (databus_addr_o === burst_addr)
                  else note_mismatch("databus_addr_o", databus_addr_o, burst_addr);
               assert (databus_len_o === LEN_W'(burst_len))
                  else note_mismatch("databus_len_o", databus_len_o, burst_len);
            end
            beat_cnt = 0;
            in_burst = 1'b1;
            bursts_checked++;
         end else if (in_burst) begin
            assert (databus_addr_o === burst_addr)
               else note_mismatch("databus_addr_o", databus_addr_o, burst_addr);
            assert (databus_len_o === LEN_W'(burst_len))
               else note_mismatch("databus_len_o", databus_len_o, burst_len);
         end
         lfsr = lfsr_step(lfsr);
         rdy = lfsr[0];
         last = rdy && in_burst && databus_valid_o === 1'b1 && (beat_cnt == burst_len - 1);
         if (rdy && databus_valid_o === 1'b1) begin
            if (exp_word_q.size() == 0) begin
               note_error("databus beat with no word expected");
            end else begin
               exp_word = exp_word_q.pop_front();
               assert (databus_wdata_o === exp_word)
                  else note_mismatch("databus_wdata_o", databus_wdata_o, exp_word);
            end
            assert (databus_wstrb_o === '1)
               else note_mismatch("databus_wstrb_o", databus_wstrb_o, 4'hf);
            beat_cnt++;
            beats_checked++;
            if (beat_cnt == burst_len) begin
               in_burst = 1'b0;
            end
         end
         stalled = (databus_valid_o === 1'b1) && !rdy;
         held_addr = databus_addr_o;
         held_len = databus_len_o;
         held_wdata = databus_wdata_o;
         if (done_o === 1'b1) begin
            assert (store_fin && !in_burst && exp_len_q.size() == 0 && exp_word_q.size() == 0)
               else note_error("done_o high before both the store and the transfer finished");
         end
      end
      databus_ready_i = rdy;
      databus_last_i = last;
   end

   task automatic wait_for_done(input int max_cycles);
      int n;
      n = 0;
      while (!timed_out && done_o !== 1'b1 && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      if (!timed_out) begin
         assert (done_o === 1'b1) else begin
            timed_out = 1'b1;
            note_error("timed out waiting for done_o to rise");
         end
      end
   endtask

   task automatic start_run(input logic xfer_en, input logic pp);
      write_enabled_i = xfer_en;
      pingpong_i = pp;
      run_i = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      assert (done_o === 1'b0) else note_mismatch("done_o", done_o, 0);
   endtask

   task automatic set_store_cfg(input logic [ADDR_W-1:0] start, input int per, input int duty,
                                input logic [ADDR_W-1:0] incr, input int iter,
                                input logic [ADDR_W-1:0] shift);
      store_start_i = start;
      store_per_i = per;
      store_duty_i = duty;
      store_incr_i = incr;
      store_iter_i = iter;
      store_shift_i = shift;
   endtask

   task automatic set_xfer_cfg(input logic [ADDR_W-1:0] start, input int per, input int duty,
                               input logic [ADDR_W-1:0] incr, input int iter,
                               input logic [ADDR_W-1:0] shift);
      xfer_start_i = start;
      xfer_per_i = per;
      xfer_duty_i = duty;
      xfer_incr_i = incr;
      xfer_iter_i = iter;
      xfer_shift_i = shift;
   endtask

   initial begin
      rst = 1'b1;
      run_i = 1'b0;
      write_enabled_i = 1'b0;
      pingpong_i = 1'b0;
      delay_i = '0;
      amount_minus_one_i = '0;
      write_length_i = 8'd1;
      ext_addr_i = '0;
      addr_shift_i = '0;
      set_store_cfg('0, 1, 1, '0, 1, '0);
      set_xfer_cfg('0, 1, 1, '0, 1, '0);
      repeat (8) @(negedge clk);
      rst = 1'b0;
      // idle after reset
      repeat (10) begin
         @(negedge clk);
         assert (done_o === 1'b1) else note_mismatch("done_o", done_o, 1);
         assert (databus_valid_o === 1'b0)
            else note_mismatch("databus_valid_o", databus_valid_o, 0);
      end
      // store only with a start delay and duty below period
      set_store_cfg(10'h020, 5, 3, 10'd2, 4, 10'd7);
      delay_i = 7'd5;
      start_run(1'b0, 1'b0);
      wait_for_done(2000);
      // read back in bursts of 5, 5, 2 while storing elsewhere
      set_store_cfg(10'h200, 4, 2, 10'd1, 3, 10'd5);
      set_xfer_cfg(10'h020, 5, 3, 10'd2, 4, 10'd7);
      amount_minus_one_i = 8'd11;
      write_length_i = 8'd5;
      ext_addr_i = 32'h0000_1000;
      addr_shift_i = 32'h0000_0040;
      start_run(1'b1, 1'b0);
      wait_for_done(4000);
      // ping-pong with the transfer reading transposed
      set_store_cfg(10'h010, 4, 4, 10'd1, 4, 10'd1);
      set_xfer_cfg(10'h010, 4, 4, 10'd4, 4, 10'd1013);
      amount_minus_one_i = 8'd15;
      write_length_i = 8'd6;
      ext_addr_i = 32'h0000_8000;
      addr_shift_i = 32'h0000_0100;
      delay_i = 7'd3;
      start_run(1'b0, 1'b1);
      wait_for_done(2000);
      start_run(1'b1, 1'b1);
      wait_for_done(4000);
      start_run(1'b1, 1'b1);
      wait_for_done(4000);
      repeat (5) @(negedge clk);
      assert (exp_word_q.size() == 0 && exp_len_q.size() == 0)
         else note_error("expected databus traffic never appeared");
      $display("beats %0d, bursts %0d, errors %0d", beats_checked, bursts_checked, error_count);
      if (error_count == 0 && !timed_out) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== build.f ====
logic/vwrite_pkg.sv
logic/vwrite_if.sv
logic/addr_gen.sv
logic/store_path.sv
logic/xfer_reader.sv
logic/databus_writer.sv
logic/vwrite_buffer.sv
logic/vwrite_ctrl.sv
logic/vwrite_top.sv
verif/vwrite_tb.sv

// ==== Bender.yml ====
package:
  name: vwrite

sources:
  - logic/vwrite_pkg.sv
  - logic/vwrite_if.sv
  - logic/addr_gen.sv
  - logic/store_path.sv
  - logic/xfer_reader.sv
  - logic/databus_writer.sv
  - logic/vwrite_buffer.sv
  - logic/vwrite_ctrl.sv
  - logic/vwrite_top.sv
  - target: test
    files:
      - verif/vwrite_tb.sv
